/* dram_scrub_ctl.f */
+incdir+include
hw/dram_scrub_ctl_pkg.sv
hw/dram_scrub_pkg.sv
hw/scrub_ctl_decode.sv
hw/scrub_engine.sv
hw/scrub_debug_id.sv
hw/dram_scrub_ctl.sv
testbench/scrub_checker.sv
testbench/tb_dram_scrub_ctl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DRAM scrub control testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f dram_scrub_ctl.f --top-module tb_dram_scrub_ctl -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/sim_tb > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q -F '*** PASSED ***' "$log_file"; then
   echo "Result: pass"
   exit 0
fi
echo "Result: fail"
exit 1

/* testbench/tb_dram_scrub_ctl.sv */
// Rows assume the row before has no enable on the same memory; every hold must be 3 or more
`include "dram_scrub_consts.svh"

module tb_dram_scrub_ctl;
   timeunit 1ns;
   timeprecision 1ps;

   // One stimulus row and the outputs expected in its last cycle
   typedef struct packed {
      logic [127:0]                  name;
      dram_scrub_ctl_pkg::ctl_word_t ctl0;
      dram_scrub_ctl_pkg::mem_mask_t ready;
      logic                          flr;
      logic [7:0]                    hold;
      logic [31:0]                   id0;
      logic [31:0]                   id1;
      dram_scrub_ctl_pkg::mem_mask_t done;
      logic                          flr_done;
   } row_t;

   localparam int num_rows     = 18;
   localparam int reset_cycles = 10;

   // An enabled row of hold H moves its memory H bursts of 0x400 in total
   // The last of them land in the first cycles of the next row
   localparam row_t row_table [num_rows] = '{
      '{"reset_ids",       32'h0000_0000, 4'h0, 1'b0, 8'd3, `DSC_ID0, `DSC_ID1, 4'h0, 1'b0},
      // A walks 3 bursts
      '{"scrub_a",         32'h0000_0001, 4'hF, 1'b0, 8'd3, `DSC_ID0, `DSC_ID1, 4'h0, 1'b0},
      '{"read_a",          32'h8000_0000, 4'hF, 1'b0, 8'd3, 32'h0000_0C00, 32'h0, 4'h0, 1'b0},
      '{"read_b",          32'h9000_0000, 4'hF, 1'b0, 8'd3, 32'h0000_0000, 32'h0, 4'h0, 1'b0},
      '{"read_sel5",       32'hD000_0000, 4'hF, 1'b0, 8'd3, 32'h0000_0C00, 32'h0, 4'h0, 1'b0},
      // Bit 2 is memory D, 4 bursts
      '{"scrub_d",         32'h0000_0004, 4'hF, 1'b0, 8'd4, `DSC_ID0, `DSC_ID1, 4'h0, 1'b0},
      '{"read_d",          32'hA000_0000, 4'hF, 1'b0, 8'd3, 32'h0000_1000, 32'h0, 4'h0, 1'b0},
      // Bit 3 is memory C, 5 bursts
      '{"scrub_c",         32'h0000_0008, 4'hF, 1'b0, 8'd5, `DSC_ID0, `DSC_ID1, 4'h0, 1'b0},
      '{"read_c",          32'hB000_0000, 4'hF, 1'b0, 8'd3, 32'h0000_1400, 32'h0, 4'h0, 1'b0},
      // A enabled but not ready
      '{"stall_not_ready", 32'h8000_0001, 4'hE, 1'b0, 8'd4, 32'h0000_0C00, 32'h0, 4'h0, 1'b0},
      // A ready but disabled
      '{"idle_ready_a",    32'h8000_0000, 4'hF, 1'b0, 8'd4, 32'h0000_0C00, 32'h0, 4'h0, 1'b0},
      // A needs 5 more bursts to reach 0x2000
      '{"scrub_a_full",    32'h0000_0001, 4'hF, 1'b0, 8'd8, `DSC_ID0, `DSC_ID1, 4'h1, 1'b0},
      '{"read_a_done",     32'h8000_0000, 4'hF, 1'b0, 8'd3, 32'h0000_2000, 32'h0, 4'h1, 1'b0},
      // FLR pulse high on odd cycles after the request registers
      '{"flr_hold_5",      32'h0000_0000, 4'h0, 1'b1, 8'd5, `DSC_ID0, `DSC_ID1, 4'h1, 1'b1},
      '{"flr_release_1",   32'h0000_0000, 4'h0, 1'b0, 8'd3, `DSC_ID0, `DSC_ID1, 4'h1, 1'b0},
      '{"flr_hold_4",      32'h0000_0000, 4'h0, 1'b1, 8'd4, `DSC_ID0, `DSC_ID1, 4'h1, 1'b0},
      '{"flr_release_2",   32'h0000_0000, 4'h0, 1'b0, 8'd3, `DSC_ID0, `DSC_ID1, 4'h1, 1'b0},
      '{"read_sel7",       32'hF000_0000, 4'hF, 1'b0, 8'd3, 32'h0000_2000, 32'h0, 4'h1, 1'b0}
   };

   logic                          clk;
   logic                          sync_rst_n;
   dram_scrub_ctl_pkg::ctl_word_t ctl0;
   dram_scrub_ctl_pkg::mem_mask_t ddr_ready;
   logic                          flr_assert;
   logic [31:0]                   id0;
   logic [31:0]                   id1;
   dram_scrub_ctl_pkg::mem_mask_t scrb_done;
   logic                          flr_done;
   // Checker request and expected values
   logic                          check_req;
   logic                          report_req;
   logic [127:0]                  row_name;
   logic [31:0]                   exp_id0;
   logic [31:0]                   exp_id1;
   dram_scrub_ctl_pkg::mem_mask_t exp_done;
   logic                          exp_flr_done;
   int                            check_count;
   int                            error_count;
   int                            cycle_count = 0;
   int                            timeout_limit = 0;

   dram_scrub_ctl dram_scrub_ctl_i
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .ddr_ready  (ddr_ready),
      .flr_assert (flr_assert),
      .id0        (id0),
      .id1        (id1),
      .scrb_done  (scrb_done),
      .flr_done   (flr_done)
   );

   scrub_checker scrub_checker_i
   (
      .clk          (clk),
      .check_req    (check_req),
      .report_req   (report_req),
      .row_name     (row_name),
      .exp_id0      (exp_id0),
      .exp_id1      (exp_id1),
      .exp_done     (exp_done),
      .exp_flr_done (exp_flr_done),
      .id0          (id0),
      .id1          (id1),
      .scrb_done    (scrb_done),
      .flr_done     (flr_done),
      .check_count  (check_count),
      .error_count  (error_count)
   );

   // --------------------
   // Clock and timeout
   // --------------------

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (timeout_limit > 0 && cycle_count >= timeout_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", timeout_limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // Sum of all row lengths
   function automatic int total_hold_cycles();
      int total;
      total = 0;
      for (int i = 0; i < num_rows; i++)
         total += int'(row_table[i].hold);
      return total;
   endfunction

   // --------------------
   // Row driver
   // --------------------

   // Drive on the first edge, flag the checker for the last cycle of the row
   task automatic apply_row(input row_t row);
      @(posedge clk);
      ctl0       <= row.ctl0;
      ddr_ready  <= row.ready;
      flr_assert <= row.flr;
      check_req  <= 1'b0;
      repeat (row.hold - 8'd1) @(posedge clk);
      row_name     <= row.name;
      exp_id0      <= row.id0;
      exp_id1      <= row.id1;
      exp_done     <= row.done;
      exp_flr_done <= row.flr_done;
      check_req    <= 1'b1;
   endtask

   initial
   begin
      sync_rst_n   <= 1'b0;
      ctl0         <= '0;
      ddr_ready    <= '0;
      flr_assert   <= 1'b0;
      check_req    <= 1'b0;
      report_req   <= 1'b0;
      row_name     <= '0;
      exp_id0      <= '0;
      exp_id1      <= '0;
      exp_done     <= '0;
      exp_flr_done <= 1'b0;
      timeout_limit = total_hold_cycles() + reset_cycles + 100;
      repeat (reset_cycles) @(posedge clk);
      sync_rst_n <= 1'b1;
      for (int i = 0; i < num_rows; i++)
         apply_row(row_table[i]);
      @(posedge clk);
      check_req  <= 1'b0;
      report_req <= 1'b1;
      @(posedge clk);
      if (error_count == 0 && check_count == num_rows)
         $display("*** PASSED ***");
      else
      begin
         if (check_count != num_rows)
            $display("Only %0d of %0d rows were checked", check_count, num_rows);
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* testbench/scrub_checker.sv */
// Compares once per row on the falling edge; row names are packed ASCII of up to 16 characters
module scrub_checker
(
   input  logic                          clk,
   input  logic                          check_req,
   input  logic                          report_req,
   input  logic [127:0]                  row_name,
   input  logic [31:0]                   exp_id0,
   input  logic [31:0]                   exp_id1,
   input  dram_scrub_ctl_pkg::mem_mask_t exp_done,
   input  logic                          exp_flr_done,
   input  logic [31:0]                   id0,
   input  logic [31:0]                   id1,
   input  dram_scrub_ctl_pkg::mem_mask_t scrb_done,
   input  logic                          flr_done,
   output int                            check_count,
   output int                            error_count
);
   timeunit 1ns;
   timeprecision 1ps;

   // Rows seen and rows with a mismatch
   int checks = 0;
   int fails  = 0;

   assign check_count = checks;
   assign error_count = fails;

   // Drops the zero padding in front of a short name
   function automatic string name_text(input logic [127:0] raw);
      string text;
      text = "";
      for (int b = 15; b >= 0; b--)
      begin
         if (raw[b*8 +: 8] != 8'h00)
            text = $sformatf("%s%c", text, raw[b*8 +: 8]);
      end
      return text;
   endfunction

   // --------------------
   // Compare
   // --------------------

   // Outputs settle after the rising edge, so the falling edge sees final values
   always @(negedge clk)
   begin
      if (check_req)
      begin
         checks = checks + 1;
         if (id0 !== exp_id0 || id1 !== exp_id1 ||
             scrb_done !== exp_done || flr_done !== exp_flr_done)
         begin
            fails = fails + 1;
            $display("CHECK FAILED %s: expected id0=%h id1=%h done=%b flr_done=%b, actual %s",
                     name_text(row_name), exp_id0, exp_id1, exp_done, exp_flr_done,
                     $sformatf("id0=%h id1=%h done=%b flr_done=%b",
                               id0, id1, scrb_done, flr_done));
         end
         else
            $display("ok %s: id0=%h id1=%h done=%b flr_done=%b",
                     name_text(row_name), id0, id1, scrb_done, flr_done);
      end
      // Closing counts line
      if (report_req)
         $display("Summary: %0d tests, %0d passed, %0d failed", checks, checks - fails, fails);
   end

endmodule

/* hw/dram_scrub_ctl.sv */
// Expects sync_rst_n already synchronized to clk; engines model the address walk only
`include "dram_scrub_consts.svh"

module dram_scrub_ctl
(
   input  logic                          clk,
   input  logic                          sync_rst_n,
   input  dram_scrub_ctl_pkg::ctl_word_t ctl0,
   input  dram_scrub_ctl_pkg::mem_mask_t ddr_ready,
   input  logic                          flr_assert,
   output logic [31:0]                   id0,
   output logic [31:0]                   id1,
   output dram_scrub_ctl_pkg::mem_mask_t scrb_done,
   output logic                          flr_done
);

   // Decoded control fields
   dram_scrub_ctl_pkg::ctl_decoded_t ctl;
   // Registered per-memory ready
   dram_scrub_ctl_pkg::mem_mask_t    ready_q;
   // One status word per engine
   dram_scrub_pkg::scrub_status_t [`DSC_NUM_MEM-1:0] mem_status;

   // --------------------
   // Decode
   // --------------------

   scrub_ctl_decode scrub_ctl_decode_i
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .ddr_ready  (ddr_ready),
      .flr_assert (flr_assert),
      .ctl        (ctl),
      .ready_q    (ready_q),
      .flr_done   (flr_done)
   );

   // --------------------
   // Scrub engines
   // --------------------

   // Engine order A, B, D, C follows the control bits
   for (genvar gi = 0; gi < `DSC_NUM_MEM; gi++)
   begin : g_engine
      scrub_engine scrub_engine_i
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (ctl.scrb_en[gi]),
         .ready      (ready_q[gi]),
         .status     (mem_status[gi])
      );

      assign scrb_done[gi] = mem_status[gi].done;
   end

   // --------------------
   // ID readout
   // --------------------

   scrub_debug_id scrub_debug_id_i
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl        (ctl),
      .mem_status (mem_status),
      .id0        (id0),
      .id1        (id1)
   );

endmodule

/* hw/scrub_debug_id.sv */
// Select values 4 to 7 read memory A; outputs lag the selected address by one clock
`include "dram_scrub_consts.svh"

module scrub_debug_id
(
   input  logic                                               clk,
   input  logic                                               sync_rst_n,
   input  dram_scrub_ctl_pkg::ctl_decoded_t                   ctl,
   input  dram_scrub_pkg::scrub_status_t [`DSC_NUM_MEM-1:0]   mem_status,
   output logic [31:0]                                        id0,
   output logic [31:0]                                        id1
);

   // Address of the engine picked by the debug select
   dram_scrub_pkg::scrub_addr_t sel_addr;

   // --------------------
   // Engine select
   // --------------------

   always_comb
   begin
      case (ctl.dbg_sel)
         3'd1:    sel_addr = mem_status[1].addr;
         // Index 2 is memory D
         3'd2:    sel_addr = mem_status[2].addr;
         // Index 3 is memory C
         3'd3:    sel_addr = mem_status[3].addr;
         // Memory A and out-of-range selects
         default: sel_addr = mem_status[0].addr;
      endcase
   end

   // --------------------
   // ID registers
   // --------------------

   // Debug on shows low and high address halves
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= `DSC_ID0;
         id1 <= `DSC_ID1;
      end
      else if (ctl.dbg_en)
      begin
         id0 <= sel_addr[31:0];
         id1 <= sel_addr[63:32];
      end
      else
      begin
         id0 <= `DSC_ID0;
         id1 <= `DSC_ID1;
      end
   end

endmodule

/* hw/scrub_engine.sv */
// Models only the address walk; no DRAM writes are issued and the range is the simulation limit
`include "dram_scrub_consts.svh"

module scrub_engine
(
   input  logic                          clk,
   input  logic                          sync_rst_n,
   input  logic                          enable,
   input  logic                          ready,
   output dram_scrub_pkg::scrub_status_t status
);

   // --------------------
   // Walk constants
   // --------------------

   // Bytes covered by one burst
   localparam dram_scrub_pkg::scrub_addr_t SCRB_STEP =
      dram_scrub_pkg::scrub_addr_t'((`DSC_SCRB_BURST_LEN_MINUS1 + 1) * `DSC_BEAT_BYTES);
   // First address past the scrub range
   localparam dram_scrub_pkg::scrub_addr_t SCRB_END = `DSC_SCRB_MAX_ADDR + 64'd1;

   dram_scrub_pkg::scrub_state_e state;
   dram_scrub_pkg::scrub_state_e state_nxt;
   dram_scrub_pkg::scrub_addr_t  addr;
   dram_scrub_pkg::scrub_addr_t  addr_nxt;

   // --------------------
   // Next state
   // --------------------

   always_comb
   begin
      state_nxt = state;
      addr_nxt  = addr;
      case (state)
         dram_scrub_pkg::SCRB_IDLE,
         dram_scrub_pkg::SCRB_RUN:
         begin
            // Disabled or memory not ready holds the walk
            if (enable && ready)
            begin
               addr_nxt  = addr + SCRB_STEP;
               state_nxt = (addr_nxt == SCRB_END) ? dram_scrub_pkg::SCRB_DONE
                                                  : dram_scrub_pkg::SCRB_RUN;
            end
         end
         // Range complete, hold until reset
         dram_scrub_pkg::SCRB_DONE:
            state_nxt = dram_scrub_pkg::SCRB_DONE;
         // Unused encoding recovers to idle
         default:
            state_nxt = dram_scrub_pkg::SCRB_IDLE;
      endcase
   end

   // --------------------
   // State and address
   // --------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state <= dram_scrub_pkg::SCRB_IDLE;
         addr  <= '0;
      end
      else
      begin
         state <= state_nxt;
         addr  <= addr_nxt;
      end
   end

   assign status.addr = addr;
   // Sticky since DONE only leaves on reset
   assign status.done = (state == dram_scrub_pkg::SCRB_DONE);

   // Walk stops at the end of the range
   addr_in_range_a : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      addr <= SCRB_END
   );

   // Done state only once the last burst has been taken
   done_at_end_a : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      (state == dram_scrub_pkg::SCRB_DONE) |-> (addr == SCRB_END)
   );

endmodule

/* hw/scrub_ctl_decode.sv */
// Inputs are registered once with no synchronizer; sync_rst_n must already be clk-synchronous
`include "dram_scrub_consts.svh"

module scrub_ctl_decode
(
   input  logic                            clk,
   input  logic                            sync_rst_n,
   input  dram_scrub_ctl_pkg::ctl_word_t   ctl0,
   input  dram_scrub_ctl_pkg::mem_mask_t   ddr_ready,
   input  logic                            flr_assert,
   output dram_scrub_ctl_pkg::ctl_decoded_t ctl,
   output dram_scrub_ctl_pkg::mem_mask_t   ready_q,
   output logic                            flr_done
);

   // --------------------
   // Input registers
   // --------------------

   // Registered shell control word
   dram_scrub_ctl_pkg::ctl_word_t ctl0_q;
   // Registered FLR request
   logic flr_assert_q;

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl0_q       <= '0;
         ready_q      <= '0;
         flr_assert_q <= 1'b0;
      end
      else
      begin
         ctl0_q       <= ctl0;
         ready_q      <= ddr_ready;
         flr_assert_q <= flr_assert;
      end
   end

   // --------------------
   // Field decode
   // --------------------

   // Low bits enable one scrubber each
   assign ctl.scrb_en = ctl0_q[`DSC_NUM_MEM-1:0];
   // Debug readout controls
   assign ctl.dbg_en  = ctl0_q[`DSC_DBG_EN_BIT];
   assign ctl.dbg_sel = ctl0_q[`DSC_DBG_SEL_MSB:`DSC_DBG_SEL_LSB];

   // --------------------
   // FLR response
   // --------------------

   // One-cycle acknowledge per request cycle pair
   // A held request toggles the response high and low
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
         flr_done <= 1'b0;
      else
         flr_done <= flr_assert_q && !flr_done;
   end

   // Response is a pulse and never held across two edges
   flr_done_pulse_a : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done
   );

endmodule

/* hw/dram_scrub_pkg.sv */
// Types for the scrub engines; addresses are full 64-bit byte addresses though only 14 bits move

package dram_scrub_pkg;

   // --------------------
   // Addressing
   // --------------------

   // Byte address of the next burst to scrub
   // Stays burst aligned in normal operation
   typedef logic [63:0] scrub_addr_t;

   // --------------------
   // Engine control
   // --------------------

   // Engine walk states
   // IDLE until the first advance
   // RUN while bursts remain
   // DONE is sticky until reset
   typedef enum logic [1:0] {
      SCRB_IDLE = 2'd0,
      SCRB_RUN  = 2'd1,
      SCRB_DONE = 2'd2
   } scrub_state_e;

   // --------------------
   // Engine status
   // --------------------

   // Status reported by each engine to the readout and the top level
   typedef struct packed {
      // Current burst start address
      scrub_addr_t addr;
      // Whole range has been walked
      logic        done;
   } scrub_status_t;

endpackage

/* hw/dram_scrub_ctl_pkg.sv */
// Types for the shell control word; memory mask width follows DSC_NUM_MEM from the consts header
`include "dram_scrub_consts.svh"

package dram_scrub_ctl_pkg;

   // --------------------
   // Raw shell control
   // --------------------

   // Control word as written by the shell
   // Bits 3..0 scrub enables, 30..28 debug select, 31 debug enable
   typedef logic [31:0] ctl_word_t;

   // Debug memory select
   // Values 4 to 7 fall back to memory A
   typedef logic [2:0] mem_sel_t;

   // One bit per memory
   // Used for scrub enables, ready flags and done flags
   typedef logic [`DSC_NUM_MEM-1:0] mem_mask_t;

   // --------------------
   // Decoded control
   // --------------------

   // Control word split into its fields
   typedef struct packed {
      // Per-memory scrub enable, A B D C from bit 0 up
      mem_mask_t scrb_en;
      // Show engine address on the ID outputs
      logic      dbg_en;
      // Engine shown when debug is on
      mem_sel_t  dbg_sel;
   } ctl_decoded_t;

endpackage

/* include/dram_scrub_consts.svh */
// Scrub limit is the 8 KiB simulation range; ID values are placeholders for the shell ID registers
`ifndef DRAM_SCRUB_CONSTS_SVH
`define DRAM_SCRUB_CONSTS_SVH

// --------------------
// Memory count
// --------------------
// Four DRAM channels in control bit order A, B, D, C
`define DSC_NUM_MEM 4

// --------------------
// Scrub walk
// --------------------
// Last byte address scrubbed in simulation
`define DSC_SCRB_MAX_ADDR 64'h1FFF
// Beats per burst minus one
`define DSC_SCRB_BURST_LEN_MINUS1 15
// Bytes per 512-bit data beat
`define DSC_BEAT_BYTES 64

// --------------------
// Control word fields
// --------------------
// Debug readout enable for the ID registers
`define DSC_DBG_EN_BIT 31
// Debug memory select field
`define DSC_DBG_SEL_MSB 30
`define DSC_DBG_SEL_LSB 28

// ID values shown while debug is off
`define DSC_ID0 32'h5C2B_0001
`define DSC_ID1 32'h0004_5C2B

`endif
